// File: Makefile
# Verilator flow for the data cache testbench

TOP = tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f dcache.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f dcache.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dcache.f
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/dcache_lookup.sv
rtl/dcache_arrays.sv
rtl/dcache_miss_engine.sv
rtl/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

// File: rtl/dcache_arrays.sv
// flop based tag, meta, data and PLRU storage with lookup and refill write ports
`timescale 1ns/1ps

module dcache_arrays #(
  parameter int IDX_WIDTH  = dcache_pkg::DEF_IDX_WIDTH,
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
) (
  input  logic         clk,
  input  logic         rst_n,
  lookup_port_if.array lk,
  refill_port_if.array rf
);
  import dcache_pkg::*;

  localparam int OFS_BITS  = $clog2(LINE_WORDS) + 2;
  localparam int TAG_WIDTH = 32 - IDX_WIDTH - OFS_BITS;
  localparam int SETS      = 1 << IDX_WIDTH;

  // hit writes leave the line dirty, refills leave it clean
  localparam meta_t META_HIT_WR  = meta_t'((2'b01 << META_VALID) | (2'b01 << META_DIRTY));
  localparam meta_t META_FILL_WR = meta_t'(2'b01 << META_VALID);

  logic [TAG_WIDTH-1:0] tag_q  [WAY_NUM][SETS];
  meta_t                meta_q [WAY_NUM][SETS];
  word_t                line_q [WAY_NUM][SETS][LINE_WORDS];
  // points at the way to replace next
  logic [SETS-1:0]      plru_q;

  // ======================================================================
  // zero latency read
  // ======================================================================
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      lk.rd_tag[w]  = tag_q[w][lk.rd_idx];
      lk.rd_meta[w] = meta_q[w][lk.rd_idx];
      lk.rd_line[w] = line_q[w][lk.rd_idx];
    end
    lk.rd_plru = plru_q[lk.rd_idx];
  end

  // ======================================================================
  // writes
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        for (int s = 0; s < SETS; s++) begin
          meta_q[w][s] <= '0;
        end
      end
      plru_q <= '0;
    end else begin
      if (lk.hit_we) begin
        meta_q[lk.wr_way][lk.rd_idx] <= META_HIT_WR;
      end
      if (rf.we) begin
        meta_q[rf.way][rf.idx] <= META_FILL_WR;
      end
      // steer away from the way just used
      if (lk.plru_upd) begin
        plru_q[lk.rd_idx] <= ~lk.wr_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lk.hit_we) begin
      line_q[lk.wr_way][lk.rd_idx] <= lk.wr_line;
    end
    if (rf.we) begin
      tag_q[rf.way][rf.idx]  <= rf.tag;
      line_q[rf.way][rf.idx] <= rf.line;
    end
  end

  // lookup stalls while the engine owns the set
  a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
    !(lk.hit_we && rf.we));

endmodule

// File: rtl/dcache_ifs.sv
// internal cache interfaces: array lookup port, array refill port, miss hand-off
`timescale 1ns/1ps

interface lookup_port_if #(
  parameter int IDX_WIDTH  = dcache_pkg::DEF_IDX_WIDTH,
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
);
  import dcache_pkg::*;
  localparam int TAG_WIDTH = 32 - IDX_WIDTH - $clog2(LINE_WORDS) - 2;

  logic [IDX_WIDTH-1:0] rd_idx;
  logic                 hit_we;
  logic                 wr_way;
  word_t                wr_line [LINE_WORDS];
  logic                 plru_upd;
  logic [TAG_WIDTH-1:0] rd_tag  [WAY_NUM];
  meta_t                rd_meta [WAY_NUM];
  word_t                rd_line [WAY_NUM][LINE_WORDS];
  logic                 rd_plru;

  modport lookup (output rd_idx, hit_we, wr_way, wr_line, plru_upd,
                  input  rd_tag, rd_meta, rd_line, rd_plru);
  modport array  (input  rd_idx, hit_we, wr_way, wr_line, plru_upd,
                  output rd_tag, rd_meta, rd_line, rd_plru);
endinterface

interface refill_port_if #(
  parameter int IDX_WIDTH  = dcache_pkg::DEF_IDX_WIDTH,
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
);
  import dcache_pkg::*;
  localparam int TAG_WIDTH = 32 - IDX_WIDTH - $clog2(LINE_WORDS) - 2;

  logic                 we;
  logic                 way;
  logic [IDX_WIDTH-1:0] idx;
  logic [TAG_WIDTH-1:0] tag;
  word_t                line [LINE_WORDS];

  modport engine (output we, way, idx, tag, line);
  modport array  (input  we, way, idx, tag, line);
endinterface

interface miss_if #(
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
);
  import dcache_pkg::*;

  logic  start;
  addr_t miss_addr;
  logic  victim_way;
  logic  victim_dirty;
  addr_t victim_addr;
  word_t victim_line [LINE_WORDS];
  logic  done;

  modport lookup (output start, miss_addr, victim_way, victim_dirty, victim_addr, victim_line,
                  input  done);
  modport engine (input  start, miss_addr, victim_way, victim_dirty, victim_addr, victim_line,
                  output done);
endinterface

// File: rtl/dcache_lookup.sv
// request pipeline: tag compare, store merge on hit, load formatting, miss hand-off
`timescale 1ns/1ps

module dcache_lookup #(
  parameter int IDX_WIDTH  = dcache_pkg::DEF_IDX_WIDTH,
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_write_i,
  input  dcache_pkg::addr_t req_addr_i,
  input  dcache_pkg::size_t req_size_i,
  input  logic              req_signed_i,
  input  dcache_pkg::word_t req_wdata_i,
  output logic              rsp_valid_o,
  output dcache_pkg::word_t rsp_rdata_o,
  lookup_port_if.lookup     arr,
  miss_if.lookup            miss
);
  import dcache_pkg::*;

  localparam int OFS_BITS  = $clog2(LINE_WORDS) + 2;
  localparam int TAG_WIDTH = 32 - IDX_WIDTH - OFS_BITS;

  // stage 1 request
  logic  s1_valid;
  logic  s1_write;
  addr_t s1_addr;
  size_t s1_size;
  logic  s1_signed;
  word_t s1_wdata;

  logic [IDX_WIDTH-1:0] s1_idx;
  logic [TAG_WIDTH-1:0] s1_tag;
  logic [OFS_BITS-3:0]  s1_word;
  logic [WAY_NUM-1:0]   hit_vec;
  logic                 hit_way;
  logic                 s1_hit;
  logic                 miss_wait;
  logic                 victim_way;
  word_t                hit_word;
  logic                 accept;
  logic                 req_aligned;

  assign s1_idx  = s1_addr[OFS_BITS +: IDX_WIDTH];
  assign s1_tag  = s1_addr[31 -: TAG_WIDTH];
  assign s1_word = s1_addr[2 +: OFS_BITS-2];

  // ======================================================================
  // tag compare
  // ======================================================================
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      hit_vec[w] = arr.rd_meta[w][META_VALID] && (arr.rd_tag[w] == s1_tag);
    end
  end

  assign hit_way  = hit_vec[1];
  assign hit_word = arr.rd_line[hit_way][s1_word];
  // held off while a refill is outstanding, the retry hits after done
  assign s1_hit   = s1_valid && (|hit_vec) && !miss_wait;

  assign req_ready_o = !s1_valid || s1_hit;
  assign accept      = req_valid_i && req_ready_o;

  // array port, stores land at the edge that retires stage 1
  assign arr.rd_idx   = s1_idx;
  assign arr.hit_we   = s1_hit && s1_write;
  assign arr.wr_way   = hit_way;
  assign arr.plru_upd = s1_hit;

  always_comb begin
    arr.wr_line          = arr.rd_line[hit_way];
    arr.wr_line[s1_word] = store_merge(hit_word, s1_wdata, s1_size, s1_addr[1:0]);
  end

  // ======================================================================
  // victim choice and miss hand-off
  // ======================================================================
  // free way first, otherwise the PLRU pick
  always_comb begin
    if (!arr.rd_meta[0][META_VALID]) begin
      victim_way = 1'b0;
    end else if (!arr.rd_meta[1][META_VALID]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = arr.rd_plru;
    end
  end

  assign miss.start        = s1_valid && !(|hit_vec) && !miss_wait;
  assign miss.miss_addr    = {s1_tag, s1_idx, {OFS_BITS{1'b0}}};
  assign miss.victim_way   = victim_way;
  assign miss.victim_dirty = arr.rd_meta[victim_way][META_VALID] &&
                             arr.rd_meta[victim_way][META_DIRTY];
  assign miss.victim_addr  = {arr.rd_tag[victim_way], s1_idx, {OFS_BITS{1'b0}}};
  assign miss.victim_line  = arr.rd_line[victim_way];

  // ======================================================================
  // pipeline registers
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      miss_wait   <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        s1_valid <= 1'b1;
      end else if (s1_hit) begin
        s1_valid <= 1'b0;
      end
      if (miss.start) begin
        miss_wait <= 1'b1;
      end else if (miss.done) begin
        miss_wait <= 1'b0;
      end
      rsp_valid_o <= s1_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_write  <= req_write_i;
      s1_addr   <= req_addr_i;
      s1_size   <= req_size_i;
      s1_signed <= req_signed_i;
      s1_wdata  <= req_wdata_i;
    end
    // stage 2 response word
    if (s1_hit) begin
      rsp_rdata_o <= load_extract(hit_word, s1_size, s1_addr[1:0], s1_signed);
    end
  end

  always_comb begin
    case (req_size_i)
      SIZE_B:  req_aligned = 1'b1;
      SIZE_H:  req_aligned = !req_addr_i[0];
      default: req_aligned = (req_addr_i[1:0] == 2'b00);
    endcase
  end

  // the core never issues misaligned accesses
  a_req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> req_aligned);

  // the engine answers only an outstanding start
  a_done_owned: assert property (@(posedge clk) disable iff (!rst_n)
    miss.done |-> miss_wait && !miss.start);

endmodule

// File: rtl/dcache_miss_engine.sv
// miss FSM: dirty victim write-back burst, refill read burst, array fill
`timescale 1ns/1ps

module dcache_miss_engine #(
  parameter int IDX_WIDTH  = dcache_pkg::DEF_IDX_WIDTH,
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
) (
  input  logic              clk,
  input  logic              rst_n,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  input  dcache_pkg::word_t mem_r_data_i,
  input  logic              mem_r_last_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  output logic              mem_w_last_o,
  miss_if.engine            miss,
  refill_port_if.engine     rf
);
  import dcache_pkg::*;

  localparam int OFS_BITS  = $clog2(LINE_WORDS) + 2;
  localparam int TAG_WIDTH = 32 - IDX_WIDTH - OFS_BITS;
  localparam int BEAT_BITS = $clog2(LINE_WORDS);
  localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(LINE_WORDS - 1);

  typedef enum logic [2:0] {
    IDLE,
    WB_ADDR,
    WB_DATA,
    RD_ADDR,
    RD_DATA,
    FILL
  } state_t;

  state_t               state_q;
  state_t               state_d;
  logic [BEAT_BITS-1:0] beat_q;
  logic                 done_q;
  logic                 way_q;
  addr_t                rd_addr_q;
  addr_t                wb_addr_q;
  word_t                wb_line_q  [LINE_WORDS];
  word_t                fill_buf_q [LINE_WORDS];
  logic                 w_fire;
  logic                 r_fire;
  logic                 last_beat;

  assign last_beat = (beat_q == LAST_BEAT);
  assign w_fire    = mem_w_valid_o && mem_w_ready_i;
  // read data is never back-pressured
  assign r_fire    = (state_q == RD_DATA) && mem_r_valid_i;

  // ======================================================================
  // state machine
  // ======================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (miss.start) state_d = miss.victim_dirty ? WB_ADDR : RD_ADDR;
      WB_ADDR: if (mem_aw_ready_i) state_d = WB_DATA;
      WB_DATA: if (w_fire && last_beat) state_d = RD_ADDR;
      RD_ADDR: if (mem_ar_ready_i) state_d = RD_DATA;
      RD_DATA: if (r_fire && last_beat) state_d = FILL;
      FILL:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == FILL);
      // full bursts only, so the counter wraps back to zero
      if (w_fire || r_fire) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // latched miss context and refill buffer
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && miss.start) begin
      way_q     <= miss.victim_way;
      rd_addr_q <= miss.miss_addr;
      wb_addr_q <= miss.victim_addr;
      wb_line_q <= miss.victim_line;
    end
    if (r_fire) begin
      fill_buf_q[beat_q] <= mem_r_data_i;
    end
  end

  // ======================================================================
  // memory bus and array fill
  // ======================================================================
  assign mem_aw_valid_o = (state_q == WB_ADDR);
  assign mem_aw_addr_o  = wb_addr_q;
  assign mem_w_valid_o  = (state_q == WB_DATA);
  assign mem_w_data_o   = wb_line_q[beat_q];
  assign mem_w_last_o   = last_beat;
  assign mem_ar_valid_o = (state_q == RD_ADDR);
  assign mem_ar_addr_o  = rd_addr_q;

  assign rf.we   = (state_q == FILL);
  assign rf.way  = way_q;
  assign rf.idx  = rd_addr_q[OFS_BITS +: IDX_WIDTH];
  assign rf.tag  = rd_addr_q[31 -: TAG_WIDTH];
  assign rf.line = fill_buf_q;

  assign miss.done = done_q;

  // memory must close the burst exactly on beat LINE_WORDS
  a_r_last: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> (mem_r_last_i == last_beat));

endmodule

// File: rtl/dcache_pkg.sv
// shared cache types, geometry defaults and the store merge / load extract helpers

package dcache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [1:0]  size_t;
  typedef logic [1:0]  meta_t;

  parameter size_t SIZE_B = 2'd0;
  parameter size_t SIZE_H = 2'd1;
  parameter size_t SIZE_W = 2'd2;

  // bit positions inside meta_t
  parameter int META_VALID = 0;
  parameter int META_DIRTY = 1;

  parameter int DEF_IDX_WIDTH  = 4;
  parameter int DEF_LINE_WORDS = 4;
  // one PLRU bit per set only works for two ways
  parameter int WAY_NUM        = 2;

  // drop store bytes into their lane of the current word
  function automatic word_t store_merge(word_t cur, word_t wdata, size_t size, logic [1:0] ofs);
    word_t res;
    res = cur;
    case (size)
      SIZE_B:  res[{ofs, 3'b000} +: 8] = wdata[7:0];
      SIZE_H:  res[{ofs[1], 4'b0000} +: 16] = wdata[15:0];
      default: res = wdata;
    endcase
    return res;
  endfunction

  // shift the addressed lane down, then sign or zero extend
  function automatic word_t load_extract(word_t word, size_t size, logic [1:0] ofs, logic sign);
    word_t shifted;
    word_t res;
    shifted = word >> {ofs, 3'b000};
    case (size)
      SIZE_B:  res = {{24{sign & shifted[7]}}, shifted[7:0]};
      SIZE_H:  res = {{16{sign & shifted[15]}}, shifted[15:0]};
      default: res = shifted;
    endcase
    return res;
  endfunction

endpackage

// File: rtl/dcache_top.sv
// cache top level: request/response and burst memory ports around lookup, arrays, miss engine
`timescale 1ns/1ps

module dcache_top #(
  parameter int IDX_WIDTH  = dcache_pkg::DEF_IDX_WIDTH,
  parameter int LINE_WORDS = dcache_pkg::DEF_LINE_WORDS
) (
  input  logic              clk,
  input  logic              rst_n,
  // core request and response
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_write_i,
  input  dcache_pkg::addr_t req_addr_i,
  input  dcache_pkg::size_t req_size_i,
  input  logic              req_signed_i,
  input  dcache_pkg::word_t req_wdata_i,
  output logic              rsp_valid_o,
  output dcache_pkg::word_t rsp_rdata_o,
  // memory read channels
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output dcache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  input  dcache_pkg::word_t mem_r_data_i,
  input  logic              mem_r_last_i,
  // memory write channels
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output dcache_pkg::addr_t mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output dcache_pkg::word_t mem_w_data_o,
  output logic              mem_w_last_o
);

  lookup_port_if #(.IDX_WIDTH(IDX_WIDTH), .LINE_WORDS(LINE_WORDS)) lk_if ();
  refill_port_if #(.IDX_WIDTH(IDX_WIDTH), .LINE_WORDS(LINE_WORDS)) rf_if ();
  miss_if        #(.LINE_WORDS(LINE_WORDS))                        ms_if ();

  dcache_lookup #(.IDX_WIDTH(IDX_WIDTH), .LINE_WORDS(LINE_WORDS)) u_lookup (
    .clk, .rst_n,
    .req_valid_i, .req_ready_o, .req_write_i, .req_addr_i,
    .req_size_i, .req_signed_i, .req_wdata_i,
    .rsp_valid_o, .rsp_rdata_o,
    .arr  (lk_if.lookup),
    .miss (ms_if.lookup)
  );

  dcache_arrays #(.IDX_WIDTH(IDX_WIDTH), .LINE_WORDS(LINE_WORDS)) u_arrays (
    .clk, .rst_n,
    .lk (lk_if.array),
    .rf (rf_if.array)
  );

  dcache_miss_engine #(.IDX_WIDTH(IDX_WIDTH), .LINE_WORDS(LINE_WORDS)) u_miss_engine (
    .clk, .rst_n,
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_r_valid_i, .mem_r_data_i, .mem_r_last_i,
    .mem_aw_valid_o, .mem_aw_ready_i, .mem_aw_addr_o,
    .mem_w_valid_o, .mem_w_ready_i, .mem_w_data_o, .mem_w_last_o,
    .miss (ms_if.engine),
    .rf   (rf_if.engine)
  );

endmodule

// File: tests/tb_dcache.sv
// cache testbench: clock, reset, directed and random stimulus, checking assertions
`timescale 1ns/1ps

module tb_dcache;

  localparam int IDX_WIDTH  = 4;
  localparam int LINE_WORDS = 4;
  localparam int TIMEOUT    = 2000;
  // byte offset bits inside one line
  localparam logic [31:0] LINE_MASK = 32'(LINE_WORDS * 4 - 1);

  logic        clk;
  logic        rst_n;
  logic        req_valid_i;
  logic        req_ready_o;
  logic        req_write_i;
  logic [31:0] req_addr_i;
  logic [1:0]  req_size_i;
  logic        req_signed_i;
  logic [31:0] req_wdata_i;
  logic        rsp_valid_o;
  logic [31:0] rsp_rdata_o;
  logic        mem_ar_valid_o, mem_ar_ready_i;
  logic [31:0] mem_ar_addr_o;
  logic        mem_r_valid_i, mem_r_last_i;
  logic [31:0] mem_r_data_i;
  logic        mem_aw_valid_o, mem_aw_ready_i;
  logic [31:0] mem_aw_addr_o;
  logic        mem_w_valid_o, mem_w_ready_i, mem_w_last_o;
  logic [31:0] mem_w_data_o;

  // outstanding requests, in order
  logic [31:0] exp_val  [256];
  logic        exp_load [256];
  logic [7:0]  wr_ptr;
  logic [7:0]  rd_ptr;
  logic [31:0] exp_head;
  logic        exp_head_load;
  logic        hit_probe;
  logic        w_fire;
  integer      seed;

  dcache_top #(.IDX_WIDTH(IDX_WIDTH), .LINE_WORDS(LINE_WORDS)) UUT (.*);

  tb_mem_model #(.LINE_WORDS(LINE_WORDS)) u_mem (
    .clk, .rst_n,
    .ar_valid_i (mem_ar_valid_o), .ar_ready_o (mem_ar_ready_i), .ar_addr_i (mem_ar_addr_o),
    .r_valid_o  (mem_r_valid_i),  .r_data_o   (mem_r_data_i),   .r_last_o  (mem_r_last_i),
    .aw_valid_i (mem_aw_valid_o), .aw_ready_o (mem_aw_ready_i), .aw_addr_i (mem_aw_addr_o),
    .w_valid_i  (mem_w_valid_o),  .w_ready_o  (mem_w_ready_i),  .w_data_i  (mem_w_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_fail;
    $display("TB FAILED");
    $fatal(1);
  endtask

  // little endian bytes from the shadow memory, then extension
  function automatic logic [31:0] expect_load(input logic [31:0] addr, input logic [1:0] size,
                                              input logic sgn);
    logic [7:0] b0, b1, b2, b3;
    logic [31:0] res;
    b0 = u_mem.shadow[addr[13:0]];
    b1 = u_mem.shadow[addr[13:0] + 14'd1];
    b2 = u_mem.shadow[addr[13:0] + 14'd2];
    b3 = u_mem.shadow[addr[13:0] + 14'd3];
    case (size)
      2'd0:    res = {{24{sgn & b0[7]}}, b0};
      2'd1:    res = {{16{sgn & b1[7]}}, b1, b0};
      default: res = {b3, b2, b1, b0};
    endcase
    return res;
  endfunction

  // ======================================================================
  // request bookkeeping
  // ======================================================================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 8'd0;
      rd_ptr <= 8'd0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        if (req_write_i) begin
          u_mem.shadow_write(req_addr_i, req_size_i, req_wdata_i);
        end
        exp_load[wr_ptr] <= !req_write_i;
        exp_val[wr_ptr]  <= expect_load(req_addr_i, req_size_i, req_signed_i);
        wr_ptr <= wr_ptr + 8'd1;
      end
      if (rsp_valid_o) begin
        rd_ptr <= rd_ptr + 8'd1;
      end
    end
  end

  assign exp_head      = exp_val[rd_ptr];
  assign exp_head_load = exp_load[rd_ptr];
  assign w_fire        = mem_w_valid_o && mem_w_ready_i;

  // ======================================================================
  // checking assertions
  // ======================================================================
  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    !mem_ar_valid_o && !mem_aw_valid_o && !mem_w_valid_o && !rsp_valid_o && req_ready_o)
    else begin
      $display("outputs were not in their reset state after reset");
      report_fail();
    end

  a_rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> (rd_ptr != wr_ptr))
    else begin
      $display("response seen with no request outstanding");
      report_fail();
    end

  a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid_o && exp_head_load) |-> (rsp_rdata_o == exp_head))
    else begin
      $display("[ERROR] %0t rsp_rdata_o: got %h expected %h", $time,
               $sampled(rsp_rdata_o), $sampled(exp_head));
      report_fail();
    end

  a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (hit_probe && req_valid_i && req_ready_o) |-> ##2 rsp_valid_o ##1 !rsp_valid_o)
    else begin
      $display("hit response did not arrive as one strobe two edges after acceptance");
      report_fail();
    end

  a_ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_ar_valid_o && mem_ar_ready_i) |-> ((mem_ar_addr_o & LINE_MASK) == 32'd0))
    else begin
      $display("[ERROR] %0t mem_ar_addr_o: got %h expected %h", $time,
               $sampled(mem_ar_addr_o), $sampled(mem_ar_addr_o) & ~LINE_MASK);
      report_fail();
    end

  a_aw_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_aw_valid_o && mem_aw_ready_i) |-> ((mem_aw_addr_o & LINE_MASK) == 32'd0))
    else begin
      $display("[ERROR] %0t mem_aw_addr_o: got %h expected %h", $time,
               $sampled(mem_aw_addr_o), $sampled(mem_aw_addr_o) & ~LINE_MASK);
      report_fail();
    end

  a_w_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> u_mem.wb_active)
    else begin
      $display("write data beat outside a write-back burst");
      report_fail();
    end

  a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> (mem_w_last_o == (u_mem.wb_beat == 8'(LINE_WORDS - 1))))
    else begin
      $display("[ERROR] %0t mem_w_last_o: got %b expected %b", $time, $sampled(mem_w_last_o),
               $sampled(u_mem.wb_beat == 8'(LINE_WORDS - 1)));
      report_fail();
    end

  a_w_data: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> (mem_w_data_o == u_mem.wb_expect))
    else begin
      $display("[ERROR] %0t mem_w_data_o: got %h expected %h", $time,
               $sampled(mem_w_data_o), $sampled(u_mem.wb_expect));
      report_fail();
    end

  // ======================================================================
  // stimulus
  // ======================================================================
  task automatic issue(input logic wr, input logic [31:0] addr, input logic [1:0] size,
                       input logic sgn, input logic [31:0] data);
    int n;
    n = 0;
    @(negedge clk);
    req_valid_i  = 1'b1;
    req_write_i  = wr;
    req_addr_i   = addr;
    req_size_i   = size;
    req_signed_i = sgn;
    req_wdata_i  = data;
    while (!req_ready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("request at %h was never accepted", addr);
        report_fail();
      end
    end
    @(posedge clk);
  endtask

  task automatic drain;
    int n;
    n = 0;
    @(negedge clk);
    req_valid_i = 1'b0;
    while (rd_ptr != wr_ptr) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("outstanding requests never received a response");
        report_fail();
      end
    end
  endtask

  task automatic random_traffic(input int count);
    logic [31:0] r;
    logic [31:0] addr;
    logic [1:0]  size;
    for (int i = 0; i < count; i++) begin
      r    = $random(seed);
      size = 2'(r[1:0] % 3);
      addr = {22'd0, r[3:2], 2'd0, r[5:4], r[7:6], 2'd0};
      if (size == 2'd0) begin
        addr[1:0] = r[9:8];
      end else if (size == 2'd1) begin
        addr[1] = r[8];
      end
      issue(r[10], addr, size, r[11], $random(seed));
    end
  endtask

  initial begin
    seed         = 4;
    hit_probe    = 1'b0;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_write_i  = 1'b0;
    req_addr_i   = 32'd0;
    req_size_i   = 2'd0;
    req_signed_i = 1'b0;
    req_wdata_i  = 32'd0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // stores of each size, then loads of every lane
    issue(1'b1, 32'h100, 2'd2, 1'b0, 32'h8765_F0A1);
    issue(1'b1, 32'h106, 2'd1, 1'b0, 32'h0000_9C3E);
    issue(1'b1, 32'h10B, 2'd0, 1'b0, 32'h0000_00D5);
    for (int b = 0; b < 4; b++) begin
      issue(1'b0, 32'h100 + b, 2'd0, 1'b1, 32'd0);
      issue(1'b0, 32'h108 + b, 2'd0, 1'b0, 32'd0);
    end
    issue(1'b0, 32'h104, 2'd1, 1'b0, 32'd0);
    issue(1'b0, 32'h106, 2'd1, 1'b1, 32'd0);
    issue(1'b0, 32'h100, 2'd2, 1'b0, 32'd0);
    issue(1'b0, 32'h108, 2'd2, 1'b0, 32'd0);
    drain();

    // second access to a resident line
    issue(1'b0, 32'h104, 2'd2, 1'b0, 32'd0);
    drain();
    hit_probe = 1'b1;
    issue(1'b0, 32'h108, 2'd2, 1'b0, 32'd0);
    hit_probe = 1'b0;
    drain();

    // three dirty lines into set 0
    issue(1'b1, 32'h1000, 2'd2, 1'b0, 32'h1111_AAAA);
    issue(1'b1, 32'h1104, 2'd2, 1'b0, 32'h2222_BBBB);
    issue(1'b1, 32'h1208, 2'd2, 1'b0, 32'h3333_CCCC);
    issue(1'b0, 32'h1000, 2'd2, 1'b0, 32'd0);
    drain();

    random_traffic(400);
    drain();

    if (u_mem.wb_count == 0) begin
      $display("no dirty write-back burst was seen");
      report_fail();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: tests/tb_mem_model.sv
// burst memory slave with random ready/valid stalls and the shadow byte memory
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int LINE_WORDS = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ar_valid_i,
  output logic        ar_ready_o,
  input  logic [31:0] ar_addr_i,
  output logic        r_valid_o,
  output logic [31:0] r_data_o,
  output logic        r_last_o,
  input  logic        aw_valid_i,
  output logic        aw_ready_o,
  input  logic [31:0] aw_addr_i,
  input  logic        w_valid_i,
  output logic        w_ready_o,
  input  logic [31:0] w_data_i
);

  localparam int MEM_WORDS = 4096;
  localparam int MEM_BYTES = MEM_WORDS * 4;

  logic [31:0] mem_q  [MEM_WORDS];
  // what the core should see, updated when a store is accepted
  logic [7:0]  shadow [MEM_BYTES];

  integer      seed;
  logic        rd_active;
  logic [31:0] rd_addr;
  logic [7:0]  rd_beat;
  logic        wb_active;
  logic [31:0] wb_addr;
  logic [7:0]  wb_beat;
  integer      wb_count;
  logic [13:0] wb_byte;
  logic [31:0] wb_expect;
  logic [31:0] init_word;

  // fill pattern built from the full byte address
  initial begin
    seed = 4;
    for (int i = 0; i < MEM_WORDS; i++) begin
      init_word = (i * 4) * 32'h9E37_79B1 ^ 32'hC0DE_1234;
      mem_q[i] = init_word;
      for (int b = 0; b < 4; b++) begin
        shadow[i * 4 + b] = init_word[b * 8 +: 8];
      end
    end
  end

  task automatic shadow_write(input logic [31:0] addr, input logic [1:0] size,
                              input logic [31:0] data);
    logic [13:0] a;
    a = addr[13:0];
    shadow[a] = data[7:0];
    if (size != 2'd0) begin
      shadow[a + 14'd1] = data[15:8];
    end
    if (size == 2'd2) begin
      shadow[a + 14'd2] = data[23:16];
      shadow[a + 14'd3] = data[31:24];
    end
  endtask

  // expected write-back word for the current beat
  assign wb_byte   = wb_addr[13:0] + {4'd0, wb_beat, 2'b00};
  assign wb_expect = {shadow[wb_byte + 14'd3], shadow[wb_byte + 14'd2],
                      shadow[wb_byte + 14'd1], shadow[wb_byte]};

  // ======================================================================
  // transfers happen on the rising edge
  // ======================================================================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      rd_beat   <= 8'd0;
      wb_active <= 1'b0;
      wb_beat   <= 8'd0;
      wb_count  <= 0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        rd_active <= 1'b1;
        rd_addr   <= ar_addr_i;
        rd_beat   <= 8'd0;
      end else if (rd_active && r_valid_o) begin
        rd_beat <= rd_beat + 8'd1;
        if (r_last_o) begin
          rd_active <= 1'b0;
        end
      end
      if (aw_valid_i && aw_ready_o) begin
        wb_active <= 1'b1;
        wb_addr   <= aw_addr_i;
        wb_beat   <= 8'd0;
      end else if (wb_active && w_valid_i && w_ready_o) begin
        mem_q[wb_addr[13:2] + {4'd0, wb_beat}] <= w_data_i;
        wb_beat <= wb_beat + 8'd1;
        if (wb_beat == 8'(LINE_WORDS - 1)) begin
          wb_active <= 1'b0;
          wb_count  <= wb_count + 1;
        end
      end
    end
  end

  // outputs change on the falling edge, with random stalls
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= 32'd0;
      r_last_o   <= 1'b0;
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
    end else begin
      ar_ready_o <= !rd_active && (($random(seed) & 3) != 0);
      aw_ready_o <= !wb_active && (($random(seed) & 3) != 0);
      w_ready_o  <= wb_active && (($random(seed) & 3) != 0);
      r_valid_o  <= rd_active && (($random(seed) & 3) != 0);
      r_data_o   <= mem_q[rd_addr[13:2] + {4'd0, rd_beat}];
      r_last_o   <= (rd_beat == 8'(LINE_WORDS - 1));
    end
  end

endmodule
